// ==== common/liic_csr_pkg.sv ====
`default_nettype none

package liic_csr_pkg;

    // Data path and timing
    localparam int unsigned CS_WIDTH     = 8;       // Register data and counter width
    localparam int unsigned CLK_FREQ     = 8000;    // Hz, kept low for short simulations
    localparam int unsigned MS_CYCLES    = (CLK_FREQ > 1000) ? CLK_FREQ / 1000 : 1;
    localparam int unsigned NUM_COUNTERS = 13;

    typedef logic [3:0]              cs_addr_t;
    typedef logic [CS_WIDTH-1:0]     cs_data_t;
    typedef logic [NUM_COUNTERS-1:0] cnt_vec_t;    // One bit per counter

    // Register map
    localparam cs_addr_t RESERVED_REG       = 4'h0;    // Always reads zero
    localparam cs_addr_t LINK_STATUS_REG    = 4'h1;
    localparam cs_addr_t LINK_ESTABLISH_CNT = 4'h2;
    localparam cs_addr_t LINK_DURATION_CNT  = 4'h3;    // Read only
    localparam cs_addr_t HPI_RCVD_CNT       = 4'h4;
    localparam cs_addr_t HPI_LOST_CNT       = 4'h5;
    localparam cs_addr_t HPO_SENT_CNT       = 4'h6;
    localparam cs_addr_t HPO_LOST_CNT       = 4'h7;
    localparam cs_addr_t LPI_RCVD_CNT       = 4'h8;
    localparam cs_addr_t LPI_LOST_CNT       = 4'h9;
    localparam cs_addr_t LPO_SENT_CNT       = 4'hA;
    localparam cs_addr_t LPO_LOST_CNT       = 4'hB;
    localparam cs_addr_t MM_STATUS_REG      = 4'hC;
    localparam cs_addr_t MM_BUSYTIMEOUT_CNT = 4'hD;
    localparam cs_addr_t MM_RVALTIMEOUT_CNT = 4'hE;
    localparam cs_addr_t MM_ODDRVAL_CNT     = 4'hF;

    // Counter indices
    localparam int unsigned CNT_LINK_ESTABLISH = 0;
    localparam int unsigned CNT_LINK_DURATION  = 1;
    localparam int unsigned CNT_HPI_RCVD       = 2;
    localparam int unsigned CNT_HPI_LOST       = 3;
    localparam int unsigned CNT_HPO_SENT       = 4;
    localparam int unsigned CNT_HPO_LOST       = 5;
    localparam int unsigned CNT_LPI_RCVD       = 6;
    localparam int unsigned CNT_LPI_LOST       = 7;
    localparam int unsigned CNT_LPO_SENT       = 8;
    localparam int unsigned CNT_LPO_LOST       = 9;
    localparam int unsigned CNT_MM_BUSYTIMEOUT = 10;
    localparam int unsigned CNT_MM_RVALTIMEOUT = 11;
    localparam int unsigned CNT_MM_ODDRVAL     = 12;

    // Counters from EV_OFFSET upwards are fed straight by event strobes
    localparam int unsigned EV_OFFSET   = CNT_HPI_RCVD;
    localparam int unsigned NUM_STROBES = NUM_COUNTERS - EV_OFFSET;

    // Counter index to register address
    localparam cs_addr_t CNT_ADDR [NUM_COUNTERS] = '{
        LINK_ESTABLISH_CNT,
        LINK_DURATION_CNT,
        HPI_RCVD_CNT,
        HPI_LOST_CNT,
        HPO_SENT_CNT,
        HPO_LOST_CNT,
        LPI_RCVD_CNT,
        LPI_LOST_CNT,
        LPO_SENT_CNT,
        LPO_LOST_CNT,
        MM_BUSYTIMEOUT_CNT,
        MM_RVALTIMEOUT_CNT,
        MM_ODDRVAL_CNT
    };

    // Status bit positions
    localparam int unsigned LINKUP_BIT         = 0;    // In LINK_STATUS_REG
    localparam int unsigned MM_BUSYTIMEOUT_BIT = 0;    // In MM_STATUS_REG
    localparam int unsigned MM_RVALTIMEOUT_BIT = 1;
    localparam int unsigned MM_ODDRVAL_BIT     = 2;

endpackage : liic_csr_pkg

`default_nettype wire

// ==== liic_csr/liic_event_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module liic_event_counter
    import liic_csr_pkg::*;
(
    input  wire logic     rst,          // Clock
    input  wire logic     clk,          // Async reset, active high

    input  wire logic     inc,
    input  wire logic     load,
    input  wire logic     clr,
    input  wire cs_data_t load_value,

    output cs_data_t      value
);

    // Priority is clear, then load, then increment
    always_ff @(posedge rst, posedge clk) begin
        if (clk) begin
            value <= '0;
        end else if (clr) begin
            value <= '0;
        end else if (load) begin
            value <= load_value;
        end else if (inc) begin
            value <= value + 1'b1;    // Wraps at CS_WIDTH
        end
    end

endmodule : liic_event_counter

`default_nettype wire

// ==== liic_csr/liic_csr_events.sv ====
`timescale 1ns/100ps
`default_nettype none

module liic_csr_events
    import liic_csr_pkg::*;
(
    input  wire logic                   rst,        // Clock
    input  wire logic                   clk,        // Async reset, active high

    input  wire logic                   ll_linkup,
    input  wire logic [NUM_STROBES-1:0] ev,         // Data and bridge strobes

    input  wire cs_addr_t               cs_addr,
    input  wire logic                   cs_wreq,

    output cnt_vec_t                    cnt_inc,
    output cnt_vec_t                    cnt_load,
    output cnt_vec_t                    cnt_clr
);

    logic linkup_dly;
    logic linkup_rise;
    logic ms_strobe;

    // Delayed copy for edge detection
    always_ff @(posedge rst, posedge clk) begin
        if (clk)
            linkup_dly <= 1'b0;
        else
            linkup_dly <= ll_linkup;
    end

    assign linkup_rise = ll_linkup & ~linkup_dly;

    // Millisecond timer
    generate
        if (MS_CYCLES > 1) begin : g_ms_timer
            localparam int unsigned MS_CNT_W = $clog2(MS_CYCLES);

            logic [MS_CNT_W-1:0] ms_cnt;
            logic                ms_q;

            always_ff @(posedge rst, posedge clk) begin
                if (clk) begin
                    ms_cnt <= '0;
                    ms_q   <= 1'b0;
                end else begin
                    if (ms_cnt == MS_CNT_W'(MS_CYCLES - 1))
                        ms_cnt <= '0;
                    else
                        ms_cnt <= ms_cnt + 1'b1;
                    ms_q <= (ms_cnt == MS_CNT_W'(MS_CYCLES - 1));    // One pulse per period
                end
            end

            assign ms_strobe = ms_q;
        end else begin : g_ms_every_cycle
            // Clock at or below 1 kHz, every cycle is a millisecond or more
            assign ms_strobe = 1'b1;
        end
    endgenerate

    // Increment sources
    always_comb begin
        cnt_inc                               = '0;
        cnt_inc[CNT_LINK_ESTABLISH]           = linkup_rise;
        cnt_inc[CNT_LINK_DURATION]            = ms_strobe;    // Held at zero by clear when down
        cnt_inc[NUM_COUNTERS-1:EV_OFFSET]     = ev;
    end

    // Write decode, one load strobe per counter
    always_comb begin
        for (int k = 0; k < NUM_COUNTERS; k++) begin
            cnt_load[k] = cs_wreq & (cs_addr == CNT_ADDR[k]);
        end
        cnt_load[CNT_LINK_DURATION] = 1'b0;    // Duration is read only
    end

    // Duration restarts whenever the link drops
    always_comb begin
        cnt_clr                    = '0;
        cnt_clr[CNT_LINK_DURATION] = ~ll_linkup;
    end

endmodule : liic_csr_events

`default_nettype wire

// ==== liic_csr/liic_csr_readback.sv ====
`timescale 1ns/100ps
`default_nettype none

module liic_csr_readback
    import liic_csr_pkg::*;
(
    input  wire logic     rst,          // Clock
    input  wire logic     clk,          // Async reset, active high

    // Monitored levels and strobes
    input  wire logic     ll_linkup,
    input  wire logic     mm_busy_timeout,
    input  wire logic     mm_rval_timeout,
    input  wire logic     mm_rval_is_odd,

    // Counter values, indexed by counter number
    input  wire cs_data_t cnt_value [NUM_COUNTERS],

    // Register port
    input  wire cs_addr_t cs_addr,
    input  wire logic     cs_wreq,
    input  wire cs_data_t cs_wdat,
    input  wire logic     cs_rreq,
    output cs_data_t      cs_rdat,
    output logic          cs_rval
);

    logic     status_wr;
    logic     busy_flag;
    logic     rval_flag;
    logic     odd_flag;
    cs_data_t rd_next;

    assign status_wr = cs_wreq & (cs_addr == MM_STATUS_REG);

    // Sticky bridge flags, a status write overrides any strobe
    always_ff @(posedge rst, posedge clk) begin
        if (clk) begin
            busy_flag <= 1'b0;
            rval_flag <= 1'b0;
            odd_flag  <= 1'b0;
        end else if (status_wr) begin
            busy_flag <= cs_wdat[MM_BUSYTIMEOUT_BIT];
            rval_flag <= cs_wdat[MM_RVALTIMEOUT_BIT];
            odd_flag  <= cs_wdat[MM_ODDRVAL_BIT];
        end else begin
            busy_flag <= busy_flag | mm_busy_timeout;
            rval_flag <= rval_flag | mm_rval_timeout;
            odd_flag  <= odd_flag | mm_rval_is_odd;
        end
    end

    // Read select
    always_comb begin
        rd_next = '0;
        case (cs_addr)
            RESERVED_REG: begin
                rd_next = '0;
            end
            LINK_STATUS_REG: begin
                rd_next[LINKUP_BIT] = ll_linkup;    // Live level, not latched
            end
            MM_STATUS_REG: begin
                rd_next[MM_BUSYTIMEOUT_BIT] = busy_flag;
                rd_next[MM_RVALTIMEOUT_BIT] = rval_flag;
                rd_next[MM_ODDRVAL_BIT]     = odd_flag;
            end
            default: begin
                // Remaining addresses all belong to counters
                for (int k = 0; k < NUM_COUNTERS; k++) begin
                    if (cs_addr == CNT_ADDR[k])
                        rd_next = cnt_value[k];
                end
            end
        endcase
    end

    // Read data is sampled every cycle, valid follows the request by one
    always_ff @(posedge rst, posedge clk) begin
        if (clk) begin
            cs_rdat <= '0;
            cs_rval <= 1'b0;
        end else begin
            cs_rdat <= rd_next;
            cs_rval <= cs_rreq;
        end
    end

endmodule : liic_csr_readback

`default_nettype wire

// ==== liic_csr/liic_csr.sv ====
`timescale 1ns/100ps
`default_nettype none

module liic_csr
    import liic_csr_pkg::*;
(
    input  wire logic     rst,              // Clock
    input  wire logic     clk,              // Async reset, active high

    // Link layer
    input  wire logic     ll_linkup,
    input  wire logic     ll_hpi_rcvd,
    input  wire logic     ll_hpi_lost,
    input  wire logic     ll_hpo_sent,
    input  wire logic     ll_hpo_lost,
    input  wire logic     ll_lpi_rcvd,
    input  wire logic     ll_lpi_lost,
    input  wire logic     ll_lpo_sent,
    input  wire logic     ll_lpo_lost,

    // Bridge
    input  wire logic     mm_busy_timeout,
    input  wire logic     mm_rval_timeout,
    input  wire logic     mm_rval_is_odd,

    // Register port
    input  wire cs_addr_t cs_addr,
    input  wire logic     cs_wreq,
    input  wire cs_data_t cs_wdat,
    input  wire logic     cs_rreq,
    output cs_data_t      cs_rdat,
    output logic          cs_rval
);

    logic [NUM_STROBES-1:0] ev;
    cnt_vec_t               cnt_inc;
    cnt_vec_t               cnt_load;
    cnt_vec_t               cnt_clr;
    cs_data_t               cnt_value [NUM_COUNTERS];

    // Strobes in counter order
    assign ev[CNT_HPI_RCVD - EV_OFFSET]       = ll_hpi_rcvd;
    assign ev[CNT_HPI_LOST - EV_OFFSET]       = ll_hpi_lost;
    assign ev[CNT_HPO_SENT - EV_OFFSET]       = ll_hpo_sent;
    assign ev[CNT_HPO_LOST - EV_OFFSET]       = ll_hpo_lost;
    assign ev[CNT_LPI_RCVD - EV_OFFSET]       = ll_lpi_rcvd;
    assign ev[CNT_LPI_LOST - EV_OFFSET]       = ll_lpi_lost;
    assign ev[CNT_LPO_SENT - EV_OFFSET]       = ll_lpo_sent;
    assign ev[CNT_LPO_LOST - EV_OFFSET]       = ll_lpo_lost;
    assign ev[CNT_MM_BUSYTIMEOUT - EV_OFFSET] = mm_busy_timeout;
    assign ev[CNT_MM_RVALTIMEOUT - EV_OFFSET] = mm_rval_timeout;
    assign ev[CNT_MM_ODDRVAL - EV_OFFSET]     = mm_rval_is_odd;

    liic_csr_events u_events (
        .rst       (rst),
        .clk       (clk),
        .ll_linkup (ll_linkup),
        .ev        (ev),
        .cs_addr   (cs_addr),
        .cs_wreq   (cs_wreq),
        .cnt_inc   (cnt_inc),
        .cnt_load  (cnt_load),
        .cnt_clr   (cnt_clr)
    );

    generate
        for (genvar k = 0; k < NUM_COUNTERS; k++) begin : g_cnt
            liic_event_counter u_cnt (
                .rst        (rst),
                .clk        (clk),
                .inc        (cnt_inc[k]),
                .load       (cnt_load[k]),
                .clr        (cnt_clr[k]),
                .load_value (cs_wdat),
                .value      (cnt_value[k])
            );
        end
    endgenerate

    liic_csr_readback u_readback (
        .rst             (rst),
        .clk             (clk),
        .ll_linkup       (ll_linkup),
        .mm_busy_timeout (mm_busy_timeout),
        .mm_rval_timeout (mm_rval_timeout),
        .mm_rval_is_odd  (mm_rval_is_odd),
        .cnt_value       (cnt_value),
        .cs_addr         (cs_addr),
        .cs_wreq         (cs_wreq),
        .cs_wdat         (cs_wdat),
        .cs_rreq         (cs_rreq),
        .cs_rdat         (cs_rdat),
        .cs_rval         (cs_rval)
    );

endmodule : liic_csr

`default_nettype wire

// ==== testbench/liic_csr_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module liic_csr_tb
    import liic_csr_pkg::*;
();

    localparam int unsigned RAND_SEED       = 32'h580f;
    localparam int          RESET_CYCLES    = 5;
    localparam int          EST_TEST_CYCLES = 2500;    // Rough length of all tests
    localparam int          TIMEOUT_CYCLES  = 2 * EST_TEST_CYCLES + 1000;
    localparam int          RVAL_WAIT_LIMIT = 4;
    localparam int          MS_PERIOD       = 8;       // Clock cycles per ms at 8 kHz
    localparam int          NUM_EV          = 11;
    localparam int          SB_BUSY         = 8;       // Busy strobe with rval and odd above it

    logic              rst;       // Clock
    logic              clk;       // Reset
    logic              ll_linkup;
    logic [NUM_EV-1:0] strobes;   // In counter order from hpi_rcvd up
    cs_addr_t          cs_addr;
    logic              cs_wreq;
    cs_data_t          cs_wdat;
    logic              cs_rreq;
    cs_data_t          cs_rdat;
    logic              cs_rval;

    int cycle_cnt;
    int error_cnt;
    int test_errors;
    int tests_run;
    int tests_failed;

    liic_csr uut (
        .rst             (rst),
        .clk             (clk),
        .ll_linkup       (ll_linkup),
        .ll_hpi_rcvd     (strobes[0]),
        .ll_hpi_lost     (strobes[1]),
        .ll_hpo_sent     (strobes[2]),
        .ll_hpo_lost     (strobes[3]),
        .ll_lpi_rcvd     (strobes[4]),
        .ll_lpi_lost     (strobes[5]),
        .ll_lpo_sent     (strobes[6]),
        .ll_lpo_lost     (strobes[7]),
        .mm_busy_timeout (strobes[8]),
        .mm_rval_timeout (strobes[9]),
        .mm_rval_is_odd  (strobes[10]),
        .cs_addr         (cs_addr),
        .cs_wreq         (cs_wreq),
        .cs_wdat         (cs_wdat),
        .cs_rreq         (cs_rreq),
        .cs_rdat         (cs_rdat),
        .cs_rval         (cs_rval)
    );

    always #10 rst = ~rst;

    always @(posedge rst) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycle_cnt);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // Register address of each strobe counter
    function automatic cs_addr_t strobe_addr(input int idx);
        case (idx)
            0:       return HPI_RCVD_CNT;
            1:       return HPI_LOST_CNT;
            2:       return HPO_SENT_CNT;
            3:       return HPO_LOST_CNT;
            4:       return LPI_RCVD_CNT;
            5:       return LPI_LOST_CNT;
            6:       return LPO_SENT_CNT;
            7:       return LPO_LOST_CNT;
            8:       return MM_BUSYTIMEOUT_CNT;
            9:       return MM_RVALTIMEOUT_CNT;
            10:      return MM_ODDRVAL_CNT;
            default: return RESERVED_REG;
        endcase
    endfunction

    task automatic check(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
            error_cnt++;
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0)
            $display("Test %s passed", name);
        else
            $display("Test %s failed with %0d errors", name, test_errors);
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        test_errors = 0;
    endtask

    task automatic write_reg(input cs_addr_t addr, input cs_data_t data);
        @(posedge rst);
        cs_addr <= addr;
        cs_wdat <= data;
        cs_wreq <= 1'b1;
        @(posedge rst);
        cs_wreq <= 1'b0;
    endtask

    // Write with the counter's own strobe high in the same cycle
    task automatic write_with_event(input cs_addr_t addr, input cs_data_t data, input int idx);
        @(posedge rst);
        cs_addr      <= addr;
        cs_wdat      <= data;
        cs_wreq      <= 1'b1;
        strobes[idx] <= 1'b1;
        @(posedge rst);
        cs_wreq      <= 1'b0;
        strobes[idx] <= 1'b0;
    endtask

    task automatic pulse_strobe(input int idx);
        @(posedge rst);
        strobes[idx] <= 1'b1;
        @(posedge rst);
        strobes[idx] <= 1'b0;
    endtask

    task automatic read_reg(input string name, input cs_addr_t addr, output cs_data_t data);
        int latency;
        bit got;
        latency = 0;
        got     = 1'b0;
        data    = '0;
        @(posedge rst);
        cs_addr <= addr;
        cs_rreq <= 1'b1;
        @(negedge rst);
        check({name, " early valid"}, 0, int'(cs_rval));
        while (!got && latency < RVAL_WAIT_LIMIT) begin
            @(posedge rst);
            cs_rreq <= 1'b0;
            latency++;
            @(negedge rst);
            got = cs_rval;
        end
        if (got) begin
            check({name, " read latency"}, 1, latency);
            data = cs_rdat;
        end else begin
            $display("%s: no read valid within %0d cycles of a read of address %0d",
                     name, RVAL_WAIT_LIMIT, addr);
            error_cnt++;
            test_errors++;
        end
    endtask

    task automatic expect_reg(input string name, input cs_addr_t addr, input int expected);
        cs_data_t data;
        read_reg(name, addr, data);
        check(name, expected, int'(data));
    endtask

    // Strobe phase can move the duration by one either way
    task automatic check_duration(input string name, input int ms, input cs_data_t actual);
        int expected;
        expected = ms;
        if (int'(actual) >= ms - 1 && int'(actual) <= ms + 1)
            expected = int'(actual);
        check(name, expected, int'(actual));
    endtask

    task automatic set_link(input logic up);
        @(posedge rst);
        ll_linkup <= up;
    endtask

    task automatic test_reset_values();
        for (int a = 0; a < 16; a++)
            expect_reg($sformatf("reset_values addr %0d", a), cs_addr_t'(a), 0);
        finish_test("reset_values");
    endtask

    // All eleven strobes run at once with separate counts
    task automatic test_strobe_counts();
        int                expected [NUM_EV];
        int                remaining [NUM_EV];
        logic [NUM_EV-1:0] next_pulse;
        bit                busy;
        for (int i = 0; i < NUM_EV; i++) begin
            expected[i]  = int'($urandom % 41);
            remaining[i] = expected[i];
        end
        busy = 1'b1;
        while (busy) begin
            busy       = 1'b0;
            next_pulse = '0;
            for (int i = 0; i < NUM_EV; i++) begin
                if (remaining[i] > 0 && ($urandom % 3) != 0) begin
                    next_pulse[i] = 1'b1;
                    remaining[i]--;
                end
                if (remaining[i] > 0)
                    busy = 1'b1;
            end
            @(posedge rst);
            strobes <= next_pulse;
        end
        @(posedge rst);
        strobes <= '0;
        for (int i = 0; i < NUM_EV; i++)
            expect_reg($sformatf("strobe_counts ctr %0d", i), strobe_addr(i), expected[i]);
        finish_test("strobe_counts");
    endtask

    task automatic test_counter_writes();
        cs_data_t value;
        int       pulses;
        string    name;
        value = cs_data_t'($urandom);
        write_reg(LINK_ESTABLISH_CNT, value);
        expect_reg("counter_writes establish", LINK_ESTABLISH_CNT, int'(value));
        for (int i = 0; i < NUM_EV; i++) begin
            name  = $sformatf("counter_writes ctr %0d", i);
            value = cs_data_t'($urandom);
            write_reg(strobe_addr(i), value);
            expect_reg({name, " load"}, strobe_addr(i), int'(value));
            value = cs_data_t'(8'hFF - ($urandom % 8));    // Close to the top so pulses wrap
            write_reg(strobe_addr(i), value);
            pulses = 8 + int'($urandom % 8);
            repeat (pulses) pulse_strobe(i);
            value = value + cs_data_t'(pulses);
            expect_reg({name, " wrap"}, strobe_addr(i), int'(value));
            value = cs_data_t'($urandom);
            write_with_event(strobe_addr(i), value, i);
            expect_reg({name, " write beats event"}, strobe_addr(i), int'(value));
        end
        finish_test("counter_writes");
    endtask

    task automatic test_link();
        cs_data_t base;
        cs_data_t dur;
        read_reg("link establish base", LINK_ESTABLISH_CNT, base);
        expect_reg("link status idle", LINK_STATUS_REG, 0);
        set_link(1'b1);
        repeat (MS_PERIOD * 3) @(posedge rst);
        write_reg(LINK_DURATION_CNT, 8'hA5);    // Must be ignored
        read_reg("link duration", LINK_DURATION_CNT, dur);
        check_duration("link duration 3 ms", 3, dur);
        expect_reg("link status up", LINK_STATUS_REG, 1 << LINKUP_BIT);
        expect_reg("link establish 1", LINK_ESTABLISH_CNT, int'(base + 8'd1));
        set_link(1'b0);
        repeat (3) @(posedge rst);
        write_reg(LINK_DURATION_CNT, 8'h5A);
        expect_reg("link duration down", LINK_DURATION_CNT, 0);
        expect_reg("link status down", LINK_STATUS_REG, 0);
        set_link(1'b1);
        repeat (MS_PERIOD * 5) @(posedge rst);
        read_reg("link duration", LINK_DURATION_CNT, dur);
        check_duration("link duration 5 ms", 5, dur);
        expect_reg("link establish 2", LINK_ESTABLISH_CNT, int'(base + 8'd2));
        set_link(1'b0);
        @(posedge rst);
        finish_test("link");
    endtask

    task automatic test_bridge_status();
        cs_data_t base [3];
        int       pulses [3];
        int       bit_pos [3];
        int       flags;
        cs_data_t pattern;
        bit_pos = '{MM_BUSYTIMEOUT_BIT, MM_RVALTIMEOUT_BIT, MM_ODDRVAL_BIT};
        write_reg(MM_STATUS_REG, 8'h00);
        expect_reg("bridge status cleared", MM_STATUS_REG, 0);
        for (int b = 0; b < 3; b++)
            read_reg("bridge base", strobe_addr(SB_BUSY + b), base[b]);
        flags = 0;
        for (int b = 0; b < 3; b++) begin
            pulses[b] = 1 + int'($urandom % 5);
            repeat (pulses[b]) pulse_strobe(SB_BUSY + b);
            flags = flags | (1 << bit_pos[b]);
            expect_reg($sformatf("bridge sticky %0d", b), MM_STATUS_REG, flags);
        end
        repeat (10) @(posedge rst);
        expect_reg("bridge sticky held", MM_STATUS_REG, flags);
        for (int b = 0; b < 3; b++)
            expect_reg($sformatf("bridge count %0d", b), strobe_addr(SB_BUSY + b),
                       int'(base[b] + cs_data_t'(pulses[b])));
        write_reg(MM_STATUS_REG, 8'h00);
        expect_reg("bridge write zero", MM_STATUS_REG, 0);
        repeat (4) begin
            pattern = cs_data_t'($urandom);
            write_reg(MM_STATUS_REG, pattern);
            expect_reg("bridge write pattern", MM_STATUS_REG, int'(pattern & 8'h07));
        end
        finish_test("bridge_status");
    endtask

    // One read request per cycle with data checked a cycle later
    task automatic test_back_to_back();
        cs_data_t model [16];
        cs_addr_t addrs [20];
        for (int a = 0; a < 16; a++)
            model[a] = '0;
        for (int i = 0; i < NUM_EV; i++) begin
            model[strobe_addr(i)] = cs_data_t'($urandom);
            write_reg(strobe_addr(i), model[strobe_addr(i)]);
        end
        model[LINK_ESTABLISH_CNT] = cs_data_t'($urandom);
        write_reg(LINK_ESTABLISH_CNT, model[LINK_ESTABLISH_CNT]);
        model[MM_STATUS_REG] = cs_data_t'($urandom % 8);
        write_reg(MM_STATUS_REG, model[MM_STATUS_REG]);
        for (int i = 0; i < 20; i++) begin
            addrs[i] = cs_addr_t'($urandom);
            if (i > 0 && addrs[i] == addrs[i-1])
                addrs[i] = addrs[i] + 4'd1;
        end
        for (int i = 0; i <= 20; i++) begin
            @(posedge rst);
            if (i < 20) begin
                cs_addr <= addrs[i];
                cs_rreq <= 1'b1;
            end else begin
                cs_rreq <= 1'b0;
            end
            @(negedge rst);
            if (i > 0) begin
                check($sformatf("back_to_back valid %0d", i - 1), 1, int'(cs_rval));
                check($sformatf("back_to_back data %0d", i - 1),
                      int'(model[addrs[i-1]]), int'(cs_rdat));
            end
        end
        @(negedge rst);
        check("back_to_back idle", 0, int'(cs_rval));
        finish_test("back_to_back");
    endtask

    initial begin
        rst          = 1'b0;
        clk          = 1'b1;
        ll_linkup    = 1'b0;
        strobes      = '0;
        cs_addr      = '0;
        cs_wreq      = 1'b0;
        cs_wdat      = '0;
        cs_rreq      = 1'b0;
        cycle_cnt    = 0;
        error_cnt    = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(RAND_SEED));
        repeat (RESET_CYCLES) @(posedge rst);
        clk <= 1'b0;
        @(posedge rst);

        test_reset_values();
        test_strobe_counts();
        test_counter_writes();
        test_link();
        test_bridge_status();
        test_back_to_back();

        $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 error_cnt);
        if (error_cnt == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule : liic_csr_tb

`default_nettype wire

// ==== project.f ====
common/liic_csr_pkg.sv
liic_csr/liic_event_counter.sv
liic_csr/liic_csr_events.sv
liic_csr/liic_csr_readback.sv
liic_csr/liic_csr.sv
testbench/liic_csr_tb.sv

// ==== Makefile ====
TOP := liic_csr_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --timescale 1ns/100ps --top-module $(TOP) -f project.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
